// File: Makefile
SIM := obj_dir/Vtb_load_store_unit

.PHONY: all run clean

all: $(SIM)

$(SIM): sources.f $(wildcard logic/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_load_store_unit -o Vtb_load_store_unit

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: logic/dcache_arbiter.sv
`timescale 1ns/1ps

module dcache_arbiter import lsq_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         flush,
    input  rob_tag_t     rob_head_tag,
    input  mem_op_t      lq_head,
    input  logic         lq_valid,
    input  mem_op_t      sq_head,
    input  logic         sq_valid,
    output logic         lq_pop,
    output logic         sq_pop,
    output logic         data_read,
    output logic         data_write,
    output logic [31:0]  data_addr,
    output logic [3:0]   data_mbe,
    output logic [31:0]  data_wdata,
    input  logic         data_resp,
    input  logic [31:0]  data_rdata,
    output load_result_t load_res,
    output logic         store_done
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t state;

    // latched copy of the issued operation
    logic      op_is_store;
    rob_tag_t  op_tag;
    mem_size_t op_size;
    logic      op_unsigned;

    logic        load_ok;
    logic        store_ok;
    logic        issue_load;
    logic        issue_store;
    mem_op_t     issue_op;
    logic [31:0] issue_addr;
    logic [31:0] shifted;
    logic [31:0] load_value;

    logic        res_valid;
    rob_tag_t    res_tag;
    logic [31:0] res_value;

    // distance from the rob head, smaller is older
    function automatic rob_tag_t age(rob_tag_t tag, rob_tag_t rob_head);
        return rob_tag_t'(tag - rob_head);
    endfunction

    function automatic logic [3:0] lanes(mem_size_t size, logic [1:0] low);
        case (size)
            mem_byte: return 4'b0001 << low;
            mem_half: return 4'b0011 << low;
            default:  return 4'b1111;
        endcase
    endfunction

    assign store_ok = sq_valid && sq_head.base.ready && sq_head.data.ready &&
                      sq_head.rob_tag == rob_head_tag;
    // store at the rob head has age zero, so it always blocks the load
    assign load_ok  = lq_valid && lq_head.base.ready &&
                      (!sq_valid ||
                       age(sq_head.rob_tag, rob_head_tag) > age(lq_head.rob_tag, rob_head_tag));

    always_comb begin
        issue_op    = sq_head;
        issue_store = 1'b0;
        issue_load  = 1'b0;
        if (state == st_idle && !flush) begin
            if (store_ok) begin
                issue_store = 1'b1;
            end else if (load_ok) begin
                issue_load = 1'b1;
                issue_op   = lq_head;
            end
        end
    end

    assign issue_addr = issue_op.base.value + {{20{issue_op.offset[11]}}, issue_op.offset};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            data_read  <= 1'b0;
            data_write <= 1'b0;
            res_valid  <= 1'b0;
            store_done <= 1'b0;
        end else begin
            res_valid  <= 1'b0;
            store_done <= 1'b0;
            if (flush) begin
                state      <= st_idle;
                data_read  <= 1'b0;
                data_write <= 1'b0;
            end else if (state == st_idle) begin
                if (issue_load || issue_store) begin
                    state      <= st_busy;
                    data_read  <= issue_load;
                    data_write <= issue_store;
                end
            end else if (data_resp) begin
                state      <= st_idle;
                data_read  <= 1'b0;
                data_write <= 1'b0;
                res_valid  <= !op_is_store;
                store_done <= op_is_store;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_load || issue_store) begin
            op_is_store <= issue_store;
            op_tag      <= issue_op.rob_tag;
            op_size     <= issue_op.size;
            op_unsigned <= issue_op.is_unsigned;
            data_addr   <= issue_addr;
            data_mbe    <= lanes(issue_op.size, issue_addr[1:0]);
            data_wdata  <= issue_op.data.value << {issue_addr[1:0], 3'b000};
        end
        if (state == st_busy && data_resp && !op_is_store) begin
            res_tag   <= op_tag;
            res_value <= load_value;
        end
    end

    // move the addressed lanes down, then extend
    always_comb begin
        shifted = data_rdata >> {data_addr[1:0], 3'b000};
        case (op_size)
            mem_byte: load_value = op_unsigned ? {24'b0, shifted[7:0]}
                                               : {{24{shifted[7]}}, shifted[7:0]};
            mem_half: load_value = op_unsigned ? {16'b0, shifted[15:0]}
                                               : {{16{shifted[15]}}, shifted[15:0]};
            default:  load_value = shifted;
        endcase
    end

    assign lq_pop   = state == st_busy && data_resp && !flush && !op_is_store;
    assign sq_pop   = state == st_busy && data_resp && !flush && op_is_store;
    assign load_res = '{valid: res_valid, rob_tag: res_tag, value: res_value};

    a_one_request_kind: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(data_read && data_write)
    );

    // held request must not move until the cache answers
    a_request_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (data_read || data_write) && !data_resp && !flush |=>
            $stable({data_read, data_write, data_addr, data_mbe, data_wdata})
    );

endmodule

// File: logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import lsq_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         flush,
    input  logic         load_push,
    input  logic         store_push,
    input  mem_op_t      op_in,
    input  cdb_t         cdb,
    input  rob_tag_t     rob_head_tag,
    input  logic         data_resp,
    input  logic [31:0]  data_rdata,
    output logic         data_read,
    output logic         data_write,
    output logic [31:0]  data_addr,
    output logic [3:0]   data_mbe,
    output logic [31:0]  data_wdata,
    output load_result_t load_res,
    output logic         store_done,
    output logic         lq_full,
    output logic         sq_full
);

    mem_op_t lq_head;
    mem_op_t sq_head;
    logic    lq_valid;
    logic    sq_valid;
    logic    lq_pop;
    logic    sq_pop;

    // loads in program order
    mem_queue #(.depth(lq_depth)) i_load_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .push       (load_push),
        .op_in      (op_in),
        .cdb        (cdb),
        .pop        (lq_pop),
        .head       (lq_head),
        .head_valid (lq_valid),
        .full       (lq_full),
        .empty      ()
    );

    // stores in program order
    mem_queue #(.depth(sq_depth)) i_store_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .push       (store_push),
        .op_in      (op_in),
        .cdb        (cdb),
        .pop        (sq_pop),
        .head       (sq_head),
        .head_valid (sq_valid),
        .full       (sq_full),
        .empty      ()
    );

    dcache_arbiter i_arbiter (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .rob_head_tag (rob_head_tag),
        .lq_head      (lq_head),
        .lq_valid     (lq_valid),
        .sq_head      (sq_head),
        .sq_valid     (sq_valid),
        .lq_pop       (lq_pop),
        .sq_pop       (sq_pop),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_addr    (data_addr),
        .data_mbe     (data_mbe),
        .data_wdata   (data_wdata),
        .data_resp    (data_resp),
        .data_rdata   (data_rdata),
        .load_res     (load_res),
        .store_done   (store_done)
    );

endmodule

// File: logic/lsq_pkg.sv
package lsq_pkg;

    // rob sizing, eight entries
    localparam int rob_tag_w = 3;

    // queue depths
    localparam int lq_depth = 4;
    localparam int sq_depth = 4;

    // result buses snooped by the queues
    localparam int num_cdb = 2;

    typedef logic [rob_tag_w-1:0] rob_tag_t;

    // one result bus slot
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] value;
    } cdb_entry_t;

    typedef cdb_entry_t [num_cdb-1:0] cdb_t;

    // value when ready, producer tag otherwise
    typedef struct packed {
        logic        ready;
        rob_tag_t    tag;
        logic [31:0] value;
    } operand_t;

    typedef enum logic [1:0] {
        mem_byte = 2'b00,
        mem_half = 2'b01,
        mem_word = 2'b10
    } mem_size_t;

    // queued memory operation, loads leave data ready
    typedef struct packed {
        rob_tag_t           rob_tag;
        mem_size_t          size;
        logic               is_unsigned;
        logic signed [11:0] offset;
        operand_t           base;
        operand_t           data;
    } mem_op_t;

    // load result towards the cdb
    typedef struct packed {
        logic        valid;
        rob_tag_t    rob_tag;
        logic [31:0] value;
    } load_result_t;

endpackage

// File: logic/mem_queue.sv
`timescale 1ns/1ps

module mem_queue import lsq_pkg::*; #(
    parameter int depth = lq_depth
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    flush,
    input  logic    push,
    input  mem_op_t op_in,
    input  cdb_t    cdb,
    input  logic    pop,
    output mem_op_t head,
    output logic    head_valid,
    output logic    full,
    output logic    empty
);

    mem_op_t entries [depth];

    logic [$clog2(depth)-1:0]   head_ptr;
    logic [$clog2(depth)-1:0]   tail_ptr;
    logic [$clog2(depth+1)-1:0] count;

    mem_op_t incoming;

    // capture a broadcast value for a waiting operand
    function automatic operand_t wake(operand_t op, cdb_t bus);
        operand_t res;
        res = op;
        for (int i = 0; i < num_cdb; i++) begin
            if (!res.ready && bus[i].valid && bus[i].tag == op.tag) begin
                res.ready = 1'b1;
                res.value = bus[i].value;
            end
        end
        return res;
    endfunction

    // operation being pushed also snoops this cycle's bus
    always_comb begin
        incoming      = op_in;
        incoming.base = wake(op_in.base, cdb);
        incoming.data = wake(op_in.data, cdb);
    end

    // payload storage with wakeup on every slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            entries[i].base <= wake(entries[i].base, cdb);
            entries[i].data <= wake(entries[i].data, cdb);
        end
        // push overrides the wakeup write of the free slot
        if (push) begin
            entries[tail_ptr] <= incoming;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= (tail_ptr == depth - 1) ? '0 : tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= (head_ptr == depth - 1) ? '0 : head_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign head       = entries[head_ptr];
    assign empty      = (count == 0);
    assign full       = (count == depth);
    assign head_valid = !empty;

    // dispatch has to respect the full flag
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        full |-> !push
    );

    // arbiter only pops a head it issued
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        empty |-> !pop
    );

endmodule

// File: sources.f
logic/lsq_pkg.sv
logic/mem_queue.sv
logic/dcache_arbiter.sv
logic/load_store_unit.sv
test/dcache_model.sv
test/tb_load_store_unit.sv

// File: test/dcache_model.sv
`timescale 1ns/1ps

module dcache_model (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        data_read,
    input  logic        data_write,
    input  logic [31:0] data_addr,
    input  logic [3:0]  data_mbe,
    input  logic [31:0] data_wdata,
    output logic        data_resp,
    output logic [31:0] data_rdata
);

    // 256 bytes, contents loaded by the testbench
    logic [7:0] mem [256];

    logic       busy;
    logic [1:0] delay;
    logic [7:0] word_base;

    assign word_base = {data_addr[7:2], 2'b00};

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            delay      <= '0;
            data_resp  <= 1'b0;
            data_rdata <= '0;
        end else begin
            data_resp <= 1'b0;
            if (data_resp || !(data_read || data_write)) begin
                // answered, or withdrawn by a flush
                busy <= 1'b0;
            end else if (!busy) begin
                busy  <= 1'b1;
                delay <= 2'($urandom % 4);
            end else if (delay != 0) begin
                delay <= delay - 1'b1;
            end else begin
                data_resp <= 1'b1;
                for (int b = 0; b < 4; b++) begin
                    data_rdata[8*b +: 8] <= mem[word_base + 8'(b)];
                    if (data_write && data_mbe[b]) begin
                        mem[word_base + 8'(b)] <= data_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: test/tb_load_store_unit.sv
`timescale 1ns/1ps

module tb_load_store_unit import lsq_pkg::*; ();

    localparam int num_tests = 6;

    logic         clk;
    logic         arst_n;
    logic         flush;
    logic         load_push;
    logic         store_push;
    mem_op_t      op_in;
    cdb_t         cdb;
    rob_tag_t     rob_head_tag;
    logic         data_resp;
    logic [31:0]  data_rdata;
    logic         data_read;
    logic         data_write;
    logic [31:0]  data_addr;
    logic [3:0]   data_mbe;
    logic [31:0]  data_wdata;
    load_result_t load_res;
    logic         store_done;
    logic         lq_full;
    logic         sq_full;

    // expected memory contents kept in step with the model
    logic [7:0] ref_mem [256];

    load_store_unit i_dut (.*);

    dcache_model i_mem (.*);

    always #2 clk = ~clk;

    function automatic operand_t ready_operand(logic [31:0] value);
        return '{ready: 1'b1, tag: '0, value: value};
    endfunction

    // data operand ready and zero until a store sets it
    function automatic mem_op_t make_op(rob_tag_t tag, mem_size_t size, logic uns,
                                        logic signed [11:0] offset, operand_t base);
        return '{rob_tag: tag, size: size, is_unsigned: uns, offset: offset,
                 base: base, data: ready_operand('0)};
    endfunction

    function automatic int byte_count(mem_size_t size);
        return (size == mem_byte) ? 1 : (size == mem_half) ? 2 : 4;
    endfunction

    // little endian bytes from the reference with extension
    function automatic logic [31:0] ref_load(logic [31:0] addr, mem_size_t size, logic uns);
        logic [31:0] v;
        int          n;
        n = byte_count(size);
        v = '0;
        for (int b = 0; b < 4; b++) begin
            if (b < n) begin
                v[8*b +: 8] = ref_mem[8'(addr + 32'(b))];
            end else if (!uns && v[8*n-1]) begin
                v[8*b +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(string what);
        $display("ERROR: %s", what);
        stop_run();
    endtask

    task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, what, exp, act);
            stop_run();
        end
    endtask

    // no cache traffic and no results for a few cycles
    task automatic expect_idle(string test, int cycles);
        repeat (cycles) begin
            step();
            assert (!data_read && !data_write && !load_res.valid && !store_done)
            else abort_run({test, ": unexpected cache request or result"});
        end
    endtask

    task automatic push_op(logic is_store, mem_op_t op);
        op_in      = op;
        load_push  = !is_store;
        store_push = is_store;
        step();
        load_push  = 1'b0;
        store_push = 1'b0;
    endtask

    task automatic run_load(string test, rob_tag_t tag, logic [31:0] addr, mem_size_t size,
                            logic uns);
        logic [31:0] exp;
        exp = ref_load(addr, size, uns);
        repeat (40) begin
            step();
            if (data_read) begin
                check_value(test, "read address", addr, data_addr);
            end
            if (load_res.valid) begin
                check_value(test, "load tag", 32'(tag), 32'(load_res.rob_tag));
                check_value(test, "load value", exp, load_res.value);
                return;
            end
        end
        abort_run({test, ": load result missing"});
    endtask

    task automatic run_store(string test, logic [31:0] addr, mem_size_t size,
                             logic [31:0] data);
        logic [3:0]  mbe;
        logic [31:0] lane_data;
        logic [31:0] mask;
        int          low;
        low       = int'(addr[1:0]);
        mbe       = '0;
        lane_data = '0;
        mask      = '0;
        for (int b = 0; b < byte_count(size); b++) begin
            mbe[low + b]                 = 1'b1;
            mask[8*(low + b) +: 8]       = 8'hff;
            lane_data[8*(low + b) +: 8]  = data[8*b +: 8];
            ref_mem[8'(addr + 32'(b))]   = data[8*b +: 8];
        end
        repeat (40) begin
            step();
            assert (!data_read)
            else abort_run({test, ": read issued before the store completed"});
            if (data_write) begin
                check_value(test, "write address", addr, data_addr);
                check_value(test, "write lanes", 32'(mbe), 32'(data_mbe));
                check_value(test, "write data", lane_data, data_wdata & mask);
            end
            if (store_done) begin
                step();
                assert (!store_done)
                else abort_run({test, ": store_done longer than one cycle"});
                return;
            end
        end
        abort_run({test, ": store completion missing"});
    endtask

    task automatic word_load();
        push_op(1'b0, make_op(3'd1, mem_word, 1'b0, 12'sd8, ready_operand(32'h40)));
        run_load("word_load", 3'd1, 32'h48, mem_word, 1'b0);
    endtask

    task automatic cdb_wakeup();
        mem_op_t op;
        op      = make_op(3'd2, mem_word, 1'b0, -12'sd4, ready_operand('0));
        op.base = '{ready: 1'b0, tag: 3'd5, value: '0};
        push_op(1'b0, op);
        expect_idle("cdb_wakeup", 5);
        // producer result on the second bus slot
        cdb[1] = '{valid: 1'b1, tag: 3'd5, value: 32'h84};
        step();
        cdb[1] = '0;
        run_load("cdb_wakeup", 3'd2, 32'h80, mem_word, 1'b0);
    endtask

    task automatic store_rob();
        mem_op_t op;
        rob_head_tag = 3'd0;
        op      = make_op(3'd3, mem_half, 1'b0, 12'sd2, ready_operand(32'h20));
        op.data = ready_operand(32'h1234_a5c3);
        push_op(1'b1, op);
        expect_idle("store_rob", 6);
        rob_head_tag = 3'd3;
        run_store("store_rob", 32'h22, mem_half, 32'h1234_a5c3);
        // read back the stored half
        push_op(1'b0, make_op(3'd4, mem_half, 1'b0, 12'sd2, ready_operand(32'h20)));
        run_load("store_rob", 3'd4, 32'h22, mem_half, 1'b0);
    endtask

    task automatic load_after_store();
        mem_op_t     op;
        logic [31:0] word;
        word         = $urandom();
        rob_head_tag = 3'd4;
        op      = make_op(3'd5, mem_word, 1'b0, 12'sd0, ready_operand(32'h30));
        op.data = ready_operand(word);
        push_op(1'b1, op);
        push_op(1'b0, make_op(3'd6, mem_word, 1'b0, 12'sd0, ready_operand(32'h30)));
        // store waits for the rob head and holds back the younger load
        expect_idle("load_after_store", 5);
        rob_head_tag = 3'd5;
        run_store("load_after_store", 32'h30, mem_word, word);
        run_load("load_after_store", 3'd6, 32'h30, mem_word, 1'b0);
    endtask

    task automatic size_extension();
        logic [31:0] base;
        rob_head_tag = 3'd0;
        for (int w = 0; w < 2; w++) begin
            base = 32'h60 + 32'(4 * w);
            for (int off = 0; off < 4; off++) begin
                for (int u = 0; u < 2; u++) begin
                    push_op(1'b0, make_op(3'd1, mem_byte, u[0], 12'(off), ready_operand(base)));
                    run_load("size_extension", 3'd1, base + 32'(off), mem_byte, u[0]);
                    if (off % 2 == 0) begin
                        push_op(1'b0, make_op(3'd1, mem_half, u[0], 12'(off),
                                              ready_operand(base)));
                        run_load("size_extension", 3'd1, base + 32'(off), mem_half, u[0]);
                    end
                end
            end
        end
    endtask

    task automatic full_and_flush();
        mem_op_t op;
        rob_head_tag = 3'd0;
        // base waits on tag 7, not broadcast before the flush
        op = make_op(3'd1, mem_word, 1'b0, 12'sd0, '{ready: 1'b0, tag: 3'd7, value: '0});
        for (int i = 0; i < 4; i++) begin
            op.rob_tag = 3'(i + 1);
            push_op(1'b0, op);
            push_op(1'b1, op);
            check_value("full_and_flush", "lq_full", 32'(i == 3), 32'(lq_full));
            check_value("full_and_flush", "sq_full", 32'(i == 3), 32'(sq_full));
        end
        flush = 1'b1;
        step();
        flush = 1'b0;
        check_value("full_and_flush", "lq_full after flush", '0, 32'(lq_full));
        check_value("full_and_flush", "sq_full after flush", '0, 32'(sq_full));
        // stale entries would wake and issue here if the flush had kept them
        cdb[0] = '{valid: 1'b1, tag: 3'd7, value: 32'h50};
        step();
        cdb[0] = '0;
        expect_idle("full_and_flush", 8);
        push_op(1'b0, make_op(3'd2, mem_word, 1'b0, 12'sd12, ready_operand(32'h50)));
        run_load("full_and_flush", 3'd2, 32'h5c, mem_word, 1'b0);
    endtask

    initial begin
        repeat (num_tests * 200) @(posedge clk);
        abort_run("watchdog expired before the tests completed");
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        flush        = 1'b0;
        load_push    = 1'b0;
        store_push   = 1'b0;
        op_in        = '0;
        cdb          = '0;
        rob_head_tag = '0;
        void'($urandom(86557));
        for (int i = 0; i < 256; i++) begin
            ref_mem[i]   = 8'(i * 29 + 7);
            i_mem.mem[i] = ref_mem[i];
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("reset", "outputs", '0,
                    32'({data_read, data_write, load_res.valid, store_done, lq_full, sq_full}));
        word_load();
        cdb_wakeup();
        store_rob();
        load_after_store();
        size_extension();
        full_and_flush();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
